//--- include/n64AdvRegMap.svh
/* Register port map of the configuration block
   Only the low field bits of a write are used, the rest read back as 0 */
`ifndef N64_ADV_REG_MAP_SVH
`define N64_ADV_REG_MAP_SVH

// Port widths
`define REG_ADDR_WIDTH  2
`define REG_DATA_WIDTH  12

// Output mode, codes from outMode_t
`define REG_MODE        2'd0
// Scanline strength, 0 is off and 3 is strongest
`define REG_SLSTR       2'd1
// Firmware version, read-only
`define REG_FWVER       2'd2

// Field widths inside the data word
`define REG_MODE_WIDTH  2
`define REG_SLSTR_WIDTH 2

`endif

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tbN64AdvTop -o simv
./obj_dir/simv | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
  echo "Simulation result: passed"
  exit 0
else
  echo "Simulation result: failed, see sim.log"
  exit 1
fi

//--- sim/tbN64AdvTop.sv
/* Drives whole four-byte frames and register accesses from a table at an 8 ns VCLK
   Writes wait for an empty pipeline, so each pixel sees one mode and one strength */
`timescale 1ns/1ps

`include "n64AdvRegMap.svh"

module tbN64AdvTop
  import n64AdvPkg::*;
;

  localparam int colorWidthO = 8;
  localparam logic [`REG_DATA_WIDTH-1:0] fwVersion = {4'd1, 8'd60};
  localparam int numEntries = 22;
  // Six frame slots per entry with room to spare, plus reset and drain
  localparam int timeoutCycles = 6 * numEntries * 4 + 100;

  // One table row holds an optional write, an optional read and one frame
  typedef struct packed {
    logic                       doWr;
    logic [1:0]                 wrAddr;
    logic [`REG_DATA_WIDTH-1:0] wrData;
    logic                       doRd;
    logic [1:0]                 rdAddr;
    logic [3:0]                 sync;
    logic [6:0]                 r;
    logic [6:0]                 g;
    logic [6:0]                 b;
    logic                       rnd;
    logic                       cutShort;
  } entry_t;

  typedef struct packed {
    logic [3*colorWidthO-1:0] word;
    logic [2:0]               syncs;
    int                       due;
  } expItem_t;

  logic                       VCLK = 1'b0;
  logic                       rst_i;
  logic                       nVDSYNC_i;
  logic [colorWidthI-1:0]     vd_i;
  logic                       cfgWrEn_i;
  logic                       cfgRdEn_i;
  logic [`REG_ADDR_WIDTH-1:0] cfgAddr_i;
  logic [`REG_DATA_WIDTH-1:0] cfgWrData_i;
  logic [`REG_DATA_WIDTH-1:0] cfgRdData_o;
  logic                       vdValid_o;
  logic [3*colorWidthO-1:0]   vd_o;
  logic                       nCSYNC_o;
  logic                       nHSYNC_o;
  logic                       nVSYNC_o;

  entry_t   stimTable [numEntries];
  expItem_t expQ [$];
  int       cycleCnt = 0;
  int       pixErrs = 0;
  int       syncErrs = 0;
  int       regErrs = 0;
  int       protoErrs = 0;

  // Reference model state
  outMode_t    mMode = OUT_RGB;
  logic [1:0]  mStr = 2'd0;
  logic [3:0]  mPrevSync = 4'hF;
  logic        mLineOdd = 1'b0;
  logic [2:0]  lastSync = 3'b111;
  logic [31:0] rngState = 32'd93;

  n64AdvTop #(.colorWidthO(colorWidthO), .fwVersion(fwVersion)) i_dut (
    .VCLK(VCLK), .rst_i(rst_i), .nVDSYNC_i(nVDSYNC_i), .vd_i(vd_i),
    .cfgWrEn_i(cfgWrEn_i), .cfgRdEn_i(cfgRdEn_i), .cfgAddr_i(cfgAddr_i),
    .cfgWrData_i(cfgWrData_i), .cfgRdData_o(cfgRdData_o),
    .vdValid_o(vdValid_o), .vd_o(vd_o),
    .nCSYNC_o(nCSYNC_o), .nHSYNC_o(nHSYNC_o), .nVSYNC_o(nVSYNC_o)
  );

  always #4 VCLK = ~VCLK;

  // Cycle count and watchdog
  always @(posedge VCLK) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= timeoutCycles) begin
      $display("Timeout after %0d cycles, the run did not finish", cycleCnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers and reference model

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic entry_t makeEntry(
    input logic doWr, input logic [1:0] wrAddr, input logic [11:0] wrData,
    input logic doRd, input logic [1:0] rdAddr, input logic [3:0] sync,
    input logic [6:0] r, input logic [6:0] g, input logic [6:0] b,
    input logic rnd, input logic cutShort
  );
    entry_t e;
    e = '{doWr, wrAddr, wrData, doRd, rdAddr, sync, r, g, b, rnd, cutShort};
    return e;
  endfunction

  // Scanline rule c - floor(c * s / 4)
  function automatic logic [6:0] dimComp(input logic [6:0] c, input logic [1:0] s);
    int v;
    v = int'(c) - (int'(c) * int'(s)) / 4;
    return 7'(v);
  endfunction

  function automatic logic [`REG_DATA_WIDTH-1:0] expectReg(input logic [1:0] addr);
    case (addr)
      `REG_MODE:  return `REG_DATA_WIDTH'(mMode);
      `REG_SLSTR: return `REG_DATA_WIDTH'(mStr);
      `REG_FWVER: return fwVersion;
      default:    return '0;
    endcase
  endfunction

  // Pushes the expected word and flags of one pixel in arrival order
  task automatic modelPixel(input logic [3:0] s, input logic [6:0] r,
                            input logic [6:0] g, input logic [6:0] b, input int due);
    logic [6:0] dr, dg, db;
    logic [7:0] wr, wg, wb;
    int         y, pb, pr;
    expItem_t   item;
    // nVSYNC fall wins over nHSYNC fall
    if (mPrevSync[3] && !s[3]) begin
      mLineOdd = 1'b0;
    end else if (mPrevSync[1] && !s[1]) begin
      mLineOdd = !mLineOdd;
    end
    mPrevSync = s;
    dr = mLineOdd ? dimComp(r, mStr) : r;
    dg = mLineOdd ? dimComp(g, mStr) : g;
    db = mLineOdd ? dimComp(b, mStr) : b;
    wr = {dr, dr[6]};
    wg = {dg, dg[6]};
    wb = {db, db[6]};
    y  = (77 * int'(wr) + 150 * int'(wg) + 29 * int'(wb)) >>> 8;
    pb = ((-43 * int'(wr) - 85 * int'(wg) + 128 * int'(wb)) >>> 8) + 128;
    pr = ((128 * int'(wr) - 107 * int'(wg) - 21 * int'(wb)) >>> 8) + 128;
    case (mMode)
      OUT_YPBPR: item.word = {y[7:0], pb[7:0], pr[7:0]};
      OUT_RGSB:  item.word = {wr, s[0] ? wg : 8'h00, wb};
      default:   item.word = {wr, wg, wb};
    endcase
    item.syncs = {s[3], s[1], s[0]};
    item.due   = due;
    expQ.push_back(item);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic checkPixel(input logic [3*colorWidthO-1:0] got,
                            input logic [3*colorWidthO-1:0] exp);
    if (got !== exp) begin
      $display("ERROR vd_o: got 0x%06h, expected 0x%06h", got, exp);
      pixErrs++;
    end
  endtask

  task automatic checkSync(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      $display("ERROR {nVSYNC_o,nHSYNC_o,nCSYNC_o}: got 0x%h, expected 0x%h", got, exp);
      syncErrs++;
    end
  endtask

  task automatic checkReg(input logic [1:0] addr, input logic [`REG_DATA_WIDTH-1:0] got,
                          input logic [`REG_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("ERROR cfgRdData_o at address %0d: got 0x%03h, expected 0x%03h",
               addr, got, exp);
      regErrs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers

  task automatic writeReg(input logic [1:0] addr, input logic [`REG_DATA_WIDTH-1:0] data);
    @(posedge VCLK);
    cfgWrEn_i   <= 1'b1;
    cfgAddr_i   <= addr;
    cfgWrData_i <= data;
    @(posedge VCLK);
    cfgWrEn_i <= 1'b0;
    // Reserved mode code is ignored
    if (addr == `REG_MODE && data[1:0] != 2'd3) begin
      mMode = outMode_t'(data[1:0]);
    end else if (addr == `REG_SLSTR) begin
      mStr = data[1:0];
    end
  endtask

  task automatic readReg(input logic [1:0] addr);
    @(posedge VCLK);
    cfgRdEn_i <= 1'b1;
    cfgAddr_i <= addr;
    @(posedge VCLK);
    cfgRdEn_i <= 1'b0;
    // Data is registered one cycle after the enable
    @(negedge VCLK);
    checkReg(addr, cfgRdData_o, expectReg(addr));
  endtask

  task automatic sendByte(input logic nSync, input logic [6:0] data);
    @(posedge VCLK);
    nVDSYNC_i <= nSync;
    vd_i      <= data;
  endtask

  task automatic sendFrame(input entry_t e);
    logic [6:0] r, g, b;
    r = e.r;
    g = e.g;
    b = e.b;
    if (e.rnd) begin
      rngState = xorshift(rngState);
      r = rngState[6:0];
      g = rngState[14:8];
      b = rngState[22:16];
    end
    // A new sync byte right after the red byte breaks the frame
    if (e.cutShort) begin
      sendByte(1'b0, {3'b000, e.sync});
      sendByte(1'b1, ~r);
    end
    sendByte(1'b0, {3'b000, e.sync});
    sendByte(1'b1, r);
    sendByte(1'b1, g);
    sendByte(1'b1, b);
    // Due four edges after the edge that drives blue
    modelPixel(e.sync, r, g, b, cycleCnt + 5);
  endtask

  task automatic drainPipe();
    while (expQ.size() != 0) begin
      @(posedge VCLK);
    end
  endtask

  task automatic buildTable();
    // RGB with strength 0
    stimTable[0]  = makeEntry(1, `REG_MODE, 12'd0, 1, `REG_MODE, 4'hF, 7'h7F, 7'h00, 7'h40, 0, 0);
    stimTable[1]  = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hF, 7'h12, 7'h34, 7'h56, 0, 0);
    stimTable[2]  = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hC, 7'h01, 7'h02, 7'h03, 0, 0);
    // RGsB blanks green while nCSYNC is low
    stimTable[3]  = makeEntry(1, `REG_MODE, 12'd1, 1, `REG_MODE, 4'hF, 7'h55, 7'h2A, 7'h7F, 0, 0);
    stimTable[4]  = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hE, 7'h00, 7'h00, 7'h00, 1, 0);
    stimTable[5]  = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hF, 7'h00, 7'h00, 7'h00, 1, 0);
    // YPbPr with random colours
    stimTable[6]  = makeEntry(1, `REG_MODE, 12'd2, 1, `REG_MODE, 4'hF, 7'h00, 7'h00, 7'h00, 1, 0);
    stimTable[7]  = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hE, 7'h00, 7'h00, 7'h00, 1, 0);
    stimTable[8]  = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'h3, 7'h00, 7'h00, 7'h00, 1, 0);
    // Scanline parity from nHSYNC and nVSYNC falls
    stimTable[9]  = makeEntry(1, `REG_MODE, 12'd0, 0, 2'd0, 4'hF, 7'h7F, 7'h7F, 7'h7F, 0, 0);
    stimTable[10] = makeEntry(1, `REG_SLSTR, 12'd1, 1, `REG_SLSTR, 4'hF, 7'h64, 7'h64, 7'h64, 0, 0);
    stimTable[11] = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hD, 7'h7F, 7'h40, 7'h21, 0, 0);
    stimTable[12] = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hF, 7'h7F, 7'h40, 7'h21, 0, 0);
    stimTable[13] = makeEntry(1, `REG_SLSTR, 12'd3, 1, `REG_SLSTR, 4'hD, 7'h33, 7'h66, 7'h7E, 0, 0);
    stimTable[14] = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hF, 7'h00, 7'h00, 7'h00, 1, 0);
    stimTable[15] = makeEntry(0, 2'd0, 12'd0, 0, 2'd0, 4'hD, 7'h00, 7'h00, 7'h00, 1, 0);
    stimTable[16] = makeEntry(1, `REG_SLSTR, 12'd2, 0, 2'd0, 4'h7, 7'h00, 7'h00, 7'h00, 1, 0);
    // Odd line in YPbPr, so a taken reserved code would change the output
    stimTable[17] = makeEntry(1, `REG_MODE, 12'd2, 0, 2'd0, 4'h5, 7'h00, 7'h00, 7'h00, 1, 0);
    // Reserved mode write, unmapped read and broken frames
    stimTable[18] = makeEntry(1, `REG_MODE, 12'd3, 1, `REG_MODE, 4'hF, 7'h00, 7'h00, 7'h00, 1, 0);
    stimTable[19] = makeEntry(0, 2'd0, 12'd0, 1, 2'd3, 4'hF, 7'h00, 7'h00, 7'h00, 1, 1);
    stimTable[20] = makeEntry(0, 2'd0, 12'd0, 1, `REG_FWVER, 4'hF, 7'h00, 7'h00, 7'h00, 1, 0);
    stimTable[21] = makeEntry(1, `REG_MODE, 12'd1, 1, `REG_MODE, 4'hC, 7'h00, 7'h00, 7'h00, 1, 1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor on the falling edge

  always @(negedge VCLK) begin
    expItem_t item;
    if (!rst_i) begin
      if (expQ.size() > 0 && expQ[0].due < cycleCnt) begin
        $display("Missing vdValid_o for the pixel due at cycle %0d", expQ[0].due);
        protoErrs++;
        item = expQ.pop_front();
      end
      if (vdValid_o) begin
        if (expQ.size() == 0) begin
          $display("Unexpected vdValid_o at cycle %0d with no pixel sent", cycleCnt);
          protoErrs++;
        end else if (expQ[0].due != cycleCnt) begin
          $display("vdValid_o early at cycle %0d, pixel due at %0d", cycleCnt, expQ[0].due);
          protoErrs++;
        end else begin
          item = expQ.pop_front();
          checkPixel(vd_o, item.word);
          checkSync({nVSYNC_o, nHSYNC_o, nCSYNC_o}, item.syncs);
          lastSync = item.syncs;
        end
      end else begin
        // Flags hold between pixels
        checkSync({nVSYNC_o, nHSYNC_o, nCSYNC_o}, lastSync);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int errTotal;
    rst_i       = 1'b1;
    nVDSYNC_i   = 1'b1;
    vd_i        = '0;
    cfgWrEn_i   = 1'b0;
    cfgRdEn_i   = 1'b0;
    cfgAddr_i   = '0;
    cfgWrData_i = '0;
    buildTable();
    repeat (2) @(posedge VCLK);
    rst_i <= 1'b0;
    // Reset values of all mapped registers
    readReg(`REG_MODE);
    readReg(`REG_SLSTR);
    readReg(`REG_FWVER);
    for (int e = 0; e < numEntries; e++) begin
      if (stimTable[e].doWr) begin
        drainPipe();
        writeReg(stimTable[e].wrAddr, stimTable[e].wrData);
      end
      if (stimTable[e].doRd) begin
        readReg(stimTable[e].rdAddr);
      end
      sendFrame(stimTable[e]);
    end
    drainPipe();
    // Catch late or extra valids
    repeat (8) @(posedge VCLK);
    errTotal = pixErrs + syncErrs + regErrs + protoErrs;
    $display("Errors: pixel %0d, sync %0d, register %0d, protocol %0d",
             pixErrs, syncErrs, regErrs, protoErrs);
    if (errTotal == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- src/n64AdvPkg.sv
/* Widths, enums and weights for the 7-bit N64 digital video bus
   Colour-space weights are scaled by 256 and match the 8-bit widened components */
package n64AdvPkg;

  ////////////////////////////////////////////////////////////////////
  // Bus widths

  // Colour depth of the N64 video bus
  localparam int colorWidthI = 7;
  // Sync nibble carried in the first byte of each frame
  localparam int syncWidth   = 4;

  ////////////////////////////////////////////////////////////////////
  // Enums

  // Output format select, code 3 is not a valid mode
  typedef enum logic [1:0] {
    OUT_RGB   = 2'd0,
    OUT_RGSB  = 2'd1,
    OUT_YPBPR = 2'd2
  } outMode_t;

  localparam logic [1:0] modeCodeReserved = 2'd3;

  // Byte slot of the four-byte video frame
  typedef enum logic [1:0] {
    PH_SYNC  = 2'd0,
    PH_RED   = 2'd1,
    PH_GREEN = 2'd2,
    PH_BLUE  = 2'd3
  } demuxPhase_t;

  ////////////////////////////////////////////////////////////////////
  // Colour-space weights

  // Luma, sums to 256
  localparam int lumaR = 77;
  localparam int lumaG = 150;
  localparam int lumaB = 29;
  // Blue difference, sums to 0
  localparam int pbR   = -43;
  localparam int pbG   = -85;
  localparam int pbB   = 128;
  // Red difference, sums to 0
  localparam int prR   = 128;
  localparam int prG   = -107;
  localparam int prB   = -21;
  // Mid-scale for both chroma channels
  localparam int chromaOffset = 128;

  // Sync nibble bit positions, all active low
  localparam int bitNVsync = 3;
  localparam int bitNClamp = 2;
  localparam int bitNHsync = 1;
  localparam int bitNCsync = 0;

endpackage

//--- src/n64AdvTop.sv
/* Output word is valid 4 VCLK cycles after the blue byte edge, no stall anywhere
   Sync outputs idle high after reset and change only with vdValid_o */
`timescale 1ns/1ps

`include "n64AdvRegMap.svh"

module n64AdvTop
  import n64AdvPkg::*;
#(
  parameter int                         colorWidthO = 8,
  parameter logic [`REG_DATA_WIDTH-1:0] fwVersion   = {4'd1, 8'd60}
) (
  // N64 video bus
  input  logic                       VCLK,
  input  logic                       rst_i,
  input  logic                       nVDSYNC_i,
  input  logic [colorWidthI-1:0]     vd_i,
  // Configuration port
  input  logic                       cfgWrEn_i,
  input  logic                       cfgRdEn_i,
  input  logic [`REG_ADDR_WIDTH-1:0] cfgAddr_i,
  input  logic [`REG_DATA_WIDTH-1:0] cfgWrData_i,
  output logic [`REG_DATA_WIDTH-1:0] cfgRdData_o,
  // To the video DAC
  output logic                       vdValid_o,
  output logic [3*colorWidthO-1:0]   vd_o,
  output logic                       nCSYNC_o,
  output logic                       nHSYNC_o,
  output logic                       nVSYNC_o
);

  // Demux to scanline
  logic                   pixValid;
  logic [colorWidthI-1:0] pixR, pixG, pixB;
  logic [syncWidth-1:0]   pixSync;

  // Scanline to converter
  logic                   slValid;
  logic [colorWidthI-1:0] slR, slG, slB;
  logic [syncWidth-1:0]   slSync;

  // Configuration
  outMode_t                     outMode;
  logic [`REG_SLSTR_WIDTH-1:0]  slStrength;
  logic [syncWidth-1:0]         syncOut;

  ////////////////////////////////////////////////////////////////////
  // Picture path

  n64VideoDemux i_demux (
    .VCLK(VCLK), .rst_i(rst_i), .nVDSYNC_i(nVDSYNC_i), .vd_i(vd_i),
    .pixValid_o(pixValid), .pixR_o(pixR), .pixG_o(pixG), .pixB_o(pixB),
    .pixSync_o(pixSync)
  );

  n64ScanlineDim i_scanline (
    .VCLK(VCLK), .rst_i(rst_i), .pixValid_i(pixValid),
    .pixR_i(pixR), .pixG_i(pixG), .pixB_i(pixB), .pixSync_i(pixSync),
    .slStrength_i(slStrength), .slValid_o(slValid),
    .slR_o(slR), .slG_o(slG), .slB_o(slB), .slSync_o(slSync)
  );

  n64ColorConv #(.colorWidthO(colorWidthO)) i_conv (
    .VCLK(VCLK), .rst_i(rst_i), .slValid_i(slValid),
    .slR_i(slR), .slG_i(slG), .slB_i(slB), .slSync_i(slSync),
    .outMode_i(outMode), .vdValid_o(vdValid_o), .vd_o(vd_o), .syncOut_o(syncOut)
  );

  // Configuration registers
  n64CfgRegs #(.fwVersion(fwVersion)) i_cfg (
    .VCLK(VCLK), .rst_i(rst_i), .cfgWrEn_i(cfgWrEn_i), .cfgRdEn_i(cfgRdEn_i),
    .cfgAddr_i(cfgAddr_i), .cfgWrData_i(cfgWrData_i), .cfgRdData_o(cfgRdData_o),
    .outMode_o(outMode), .slStrength_o(slStrength)
  );

  // nCLAMP stays internal
  assign nCSYNC_o = syncOut[bitNCsync];
  assign nHSYNC_o = syncOut[bitNHsync];
  assign nVSYNC_o = syncOut[bitNVsync];

endmodule

//--- src/n64CfgRegs.sv
/* Writes land on the enabled edge, reads return one cycle after cfgRdEn_i
   A mode write of the reserved code is dropped, unmapped reads give 0 */
`timescale 1ns/1ps

`include "n64AdvRegMap.svh"

module n64CfgRegs
  import n64AdvPkg::*;
#(
  parameter logic [`REG_DATA_WIDTH-1:0] fwVersion = {4'd1, 8'd60}
) (
  input  logic                          VCLK,
  input  logic                          rst_i,
  input  logic                          cfgWrEn_i,
  input  logic                          cfgRdEn_i,
  input  logic [`REG_ADDR_WIDTH-1:0]    cfgAddr_i,
  input  logic [`REG_DATA_WIDTH-1:0]    cfgWrData_i,
  output logic [`REG_DATA_WIDTH-1:0]    cfgRdData_o,
  output outMode_t                      outMode_o,
  output logic [`REG_SLSTR_WIDTH-1:0]   slStrength_o
);

  localparam int dataW = `REG_DATA_WIDTH;

  // Mode field of the incoming write
  logic [`REG_MODE_WIDTH-1:0] modeField;

  assign modeField = cfgWrData_i[`REG_MODE_WIDTH-1:0];

  ////////////////////////////////////////////////////////////////////
  // Write side

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      outMode_o    <= OUT_RGB;
      slStrength_o <= '0;
    end else if (cfgWrEn_i) begin
      case (cfgAddr_i)
        `REG_MODE: begin
          // Reserved code keeps the previous mode
          if (modeField != modeCodeReserved) begin
            outMode_o <= outMode_t'(modeField);
          end
        end
        `REG_SLSTR: slStrength_o <= cfgWrData_i[`REG_SLSTR_WIDTH-1:0];
        default: ;  // Version is read-only
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Registered read-back

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      cfgRdData_o <= '0;
    end else if (cfgRdEn_i) begin
      case (cfgAddr_i)
        `REG_MODE:  cfgRdData_o <= dataW'(outMode_o);
        `REG_SLSTR: cfgRdData_o <= dataW'(slStrength_o);
        `REG_FWVER: cfgRdData_o <= fwVersion;
        default:    cfgRdData_o <= '0;
      endcase
    end
  end

  // Converter relies on never seeing the reserved code
  modeNeverReserved: assert property (
    @(posedge VCLK) disable iff (rst_i) outMode_o != outMode_t'(modeCodeReserved)
  );

endmodule

//--- src/n64ColorConv.sv
/* Two VCLK stages, the mode is captured with each pixel as it enters
   Components are 8 bits inside and rescaled to colorWidthO bits on output */
`timescale 1ns/1ps

module n64ColorConv
  import n64AdvPkg::*;
#(
  parameter int colorWidthO = 8
) (
  input  logic                     VCLK,
  input  logic                     rst_i,
  input  logic                     slValid_i,
  input  logic [colorWidthI-1:0]   slR_i,
  input  logic [colorWidthI-1:0]   slG_i,
  input  logic [colorWidthI-1:0]   slB_i,
  input  logic [syncWidth-1:0]     slSync_i,
  input  outMode_t                 outMode_i,
  output logic                     vdValid_o,
  output logic [3*colorWidthO-1:0] vd_o,
  output logic [syncWidth-1:0]     syncOut_o
);

  localparam int compW = colorWidthI + 1;

  // Widened inputs
  logic [compW-1:0] rWide, gWide, bWide;

  // Stage 1
  logic                    valid1;
  logic [compW-1:0]        r1, g1, b1;
  logic signed [17:0]      ySum1, pbSum1, prSum1;
  logic [syncWidth-1:0]    sync1;
  outMode_t                mode1;

  // Stage 2 inputs
  logic signed [17:0]      yShr, pbShr, prShr;
  logic [compW-1:0]        compA, compB, compC;

  // Weighted sum of the three components
  function automatic logic signed [17:0] weigh(
    input int               kR,
    input int               kG,
    input int               kB,
    input logic [compW-1:0] r,
    input logic [compW-1:0] g,
    input logic [compW-1:0] b
  );
    int acc;
    acc = kR * int'(r) + kG * int'(g) + kB * int'(b);
    return 18'(acc);
  endfunction

  // Keeps the top bits when narrowing, pads with zeros when widening
  function automatic logic [colorWidthO-1:0] fitOut(input logic [compW-1:0] c);
    logic [colorWidthO+compW-1:0] ext;
    ext = {c, {colorWidthO{1'b0}}} >> compW;
    return ext[colorWidthO-1:0];
  endfunction

  // Top bit repeated into the new LSB so full scale stays full scale
  assign rWide = {slR_i, slR_i[colorWidthI-1]};
  assign gWide = {slG_i, slG_i[colorWidthI-1]};
  assign bWide = {slB_i, slB_i[colorWidthI-1]};

  ////////////////////////////////////////////////////////////////////
  // Stage 1, weighted sums

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      valid1 <= 1'b0;
    end else begin
      valid1 <= slValid_i;
    end
  end

  always_ff @(posedge VCLK) begin
    if (slValid_i) begin
      r1     <= rWide;
      g1     <= gWide;
      b1     <= bWide;
      ySum1  <= weigh(lumaR, lumaG, lumaB, rWide, gWide, bWide);
      pbSum1 <= weigh(pbR, pbG, pbB, rWide, gWide, bWide);
      prSum1 <= weigh(prR, prG, prB, rWide, gWide, bWide);
      sync1  <= slSync_i;
      mode1  <= outMode_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stage 2, scale and select

  // Arithmetic shift floors negative chroma
  assign yShr  = ySum1 >>> 8;
  assign pbShr = (pbSum1 >>> 8) + 18'(chromaOffset);
  assign prShr = (prSum1 >>> 8) + 18'(chromaOffset);

  always_comb begin
    case (mode1)
      OUT_YPBPR: begin
        compA = yShr[compW-1:0];
        compB = pbShr[compW-1:0];
        compC = prShr[compW-1:0];
      end
      OUT_RGSB: begin
        compA = r1;
        compB = sync1[bitNCsync] ? g1 : '0;  // Sync rides on green
        compC = b1;
      end
      default: begin
        compA = r1;
        compB = g1;
        compC = b1;
      end
    endcase
  end

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      vdValid_o <= 1'b0;
      syncOut_o <= '1;
    end else begin
      vdValid_o <= valid1;
      // Sync flags only advance with a pixel
      if (valid1) begin
        syncOut_o <= sync1;
      end
    end
  end

  always_ff @(posedge VCLK) begin
    if (valid1) begin
      vd_o <= {fitOut(compA), fitOut(compB), fitOut(compC)};
    end
  end

  // Fixed two-cycle latency, no pixel lost or duplicated
  convLatency: assert property (
    @(posedge VCLK) disable iff (rst_i) vdValid_o == $past(slValid_i, 2)
  );

endmodule

//--- src/n64ScanlineDim.sv
/* Line parity follows nHSYNC falls between valid pixels and resets on nVSYNC fall
   Odd lines lose floor(c*strength/4), so strength 0 leaves every line untouched */
`timescale 1ns/1ps

module n64ScanlineDim
  import n64AdvPkg::*;
(
  input  logic                   VCLK,
  input  logic                   rst_i,
  input  logic                   pixValid_i,
  input  logic [colorWidthI-1:0] pixR_i,
  input  logic [colorWidthI-1:0] pixG_i,
  input  logic [colorWidthI-1:0] pixB_i,
  input  logic [syncWidth-1:0]   pixSync_i,
  input  logic [1:0]             slStrength_i,
  output logic                   slValid_o,
  output logic [colorWidthI-1:0] slR_o,
  output logic [colorWidthI-1:0] slG_o,
  output logic [colorWidthI-1:0] slB_o,
  output logic [syncWidth-1:0]   slSync_o
);

  // Sync nibble of the previous valid pixel
  logic [syncWidth-1:0] prevSync;
  logic                 lineOdd;
  logic                 hFall;
  logic                 vFall;
  logic                 oddNow;

  // c - floor(c * s / 4)
  function automatic logic [colorWidthI-1:0] dim(
    input logic [colorWidthI-1:0] c,
    input logic [1:0]             s
  );
    logic [colorWidthI+1:0] prod;
    prod = c * s;
    return c - prod[colorWidthI+1:2];
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Line parity

  // Edges only count between consecutive valid pixels
  assign hFall  = prevSync[bitNHsync] && !pixSync_i[bitNHsync];
  assign vFall  = prevSync[bitNVsync] && !pixSync_i[bitNVsync];
  // Parity that applies to the current pixel
  assign oddNow = vFall ? 1'b0 : (lineOdd ^ hFall);

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      prevSync  <= '1;
      lineOdd   <= 1'b0;
      slValid_o <= 1'b0;
    end else begin
      slValid_o <= pixValid_i;
      if (pixValid_i) begin
        prevSync <= pixSync_i;
        lineOdd  <= oddNow;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Darkening

  always_ff @(posedge VCLK) begin
    if (pixValid_i) begin
      slSync_o <= pixSync_i;
      if (oddNow) begin
        slR_o <= dim(pixR_i, slStrength_i);
        slG_o <= dim(pixG_i, slStrength_i);
        slB_o <= dim(pixB_i, slStrength_i);
      end else begin
        slR_o <= pixR_i;
        slG_o <= pixG_i;
        slB_o <= pixB_i;
      end
    end
  end

endmodule

//--- src/n64VideoDemux.sv
/* Expects nVDSYNC low on the sync byte, then R, G, B on the next three VCLK edges
   A sync byte before blue drops the partial pixel without any output */
`timescale 1ns/1ps

module n64VideoDemux
  import n64AdvPkg::*;
(
  input  logic                   VCLK,
  input  logic                   rst_i,
  input  logic                   nVDSYNC_i,
  input  logic [colorWidthI-1:0] vd_i,
  output logic                   pixValid_o,
  output logic [colorWidthI-1:0] pixR_o,
  output logic [colorWidthI-1:0] pixG_o,
  output logic [colorWidthI-1:0] pixB_o,
  output logic [syncWidth-1:0]   pixSync_o
);

  // Phase holds the byte slot expected on the next edge
  demuxPhase_t phase;

  // Partial frame, kept until blue arrives
  logic [syncWidth-1:0]   syncHold;
  logic [colorWidthI-1:0] redHold;
  logic [colorWidthI-1:0] greenHold;

  // Blue is on the bus in this cycle
  logic blueNow;

  assign blueNow = nVDSYNC_i && (phase == PH_BLUE);

  ////////////////////////////////////////////////////////////////////
  // Frame FSM

  always_ff @(posedge VCLK) begin
    if (rst_i) begin
      phase      <= PH_SYNC;
      pixValid_o <= 1'b0;
    end else begin
      pixValid_o <= blueNow;
      if (!nVDSYNC_i) begin
        // Sync byte always restarts the frame
        phase <= PH_RED;
      end else begin
        case (phase)
          PH_RED:   phase <= PH_GREEN;
          PH_GREEN: phase <= PH_BLUE;
          PH_BLUE:  phase <= PH_SYNC;
          default:  phase <= PH_SYNC;  // Idle until the next sync byte
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Byte capture

  always_ff @(posedge VCLK) begin
    if (!nVDSYNC_i) begin
      syncHold <= vd_i[syncWidth-1:0];
    end
    if (nVDSYNC_i && (phase == PH_RED)) begin
      redHold <= vd_i;
    end
    if (nVDSYNC_i && (phase == PH_GREEN)) begin
      greenHold <= vd_i;
    end
    // Whole pixel moves out at once so it is stable during the pulse
    if (blueNow) begin
      pixR_o    <= redHold;
      pixG_o    <= greenHold;
      pixB_o    <= vd_i;
      pixSync_o <= syncHold;
    end
  end

  // A frame is four bytes, so two pixels can never be back to back
  pixValidSpacing: assert property (
    @(posedge VCLK) disable iff (rst_i) pixValid_o |=> !pixValid_o
  );

endmodule

//--- vlog.f
+incdir+include
src/n64AdvPkg.sv
src/n64VideoDemux.sv
src/n64CfgRegs.sv
src/n64ScanlineDim.sv
src/n64ColorConv.sv
src/n64AdvTop.sv
sim/tbN64AdvTop.sv
